/* hw/timer_pkg.sv */
// timer package: shared widths, register map, mode encodings and bus/event structs
`default_nettype none

package timer_pkg;

    localparam int cnt_w   = 16;   // counter and bus data width
    localparam int addr_w  = 3;    // register address width
    localparam int presc_w = 10;   // prescaler divider width

    // divider wrap values, ratio minus one
    localparam logic [presc_w-1:0] div8_last    = 10'd7;
    localparam logic [presc_w-1:0] div64_last   = 10'd63;
    localparam logic [presc_w-1:0] div256_last  = 10'd255;
    localparam logic [presc_w-1:0] div1024_last = 10'd1023;

    localparam logic [cnt_w-1:0] cnt_max = '1;   // top in normal mode

    typedef enum logic [addr_w-1:0] {
        addr_ctrl  = 3'd0,
        addr_cnt   = 3'd1,
        addr_ocr_a = 3'd2,
        addr_ocr_b = 3'd3,
        addr_flags = 3'd4
    } reg_addr_e;

    typedef enum logic {
        mode_normal = 1'b0,
        mode_ctc    = 1'b1   // clear on match with compare A
    } wave_mode_e;

    typedef enum logic [1:0] {
        com_off    = 2'd0,
        com_toggle = 2'd1,
        com_clear  = 2'd2,
        com_set    = 2'd3
    } com_mode_e;

    typedef enum logic [2:0] {
        cs_stop     = 3'd0,
        cs_div1     = 3'd1,
        cs_div8     = 3'd2,
        cs_div64    = 3'd3,
        cs_div256   = 3'd4,
        cs_div1024  = 3'd5,
        cs_ext_fall = 3'd6,   // no external clock, acts as stop
        cs_ext_rise = 3'd7
    } clk_sel_e;

    // control bits 7..0, wave lands on bit 0
    typedef struct packed {
        clk_sel_e   cs;
        com_mode_e  com_b;
        com_mode_e  com_a;
        wave_mode_e wave;
    } timer_ctrl_t;

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [addr_w-1:0] addr;
        logic [cnt_w-1:0]  wdata;
    } bus_req_t;

    // flag layout: ovf bit 0, match_b bit 1, match_a bit 2
    typedef struct packed {
        logic match_a;
        logic match_b;
        logic ovf;
    } timer_evt_t;

endpackage

`default_nettype wire

/* hw/timer_prescaler.sv */
// timer prescaler: turns the clock-select code into a periodic one-cycle tick
`timescale 1ns/1ps
`default_nettype none

module timer_prescaler import timer_pkg::*; (
    input  logic     clk_in,
    input  logic     rst,
    input  clk_sel_e cs,
    output logic     tick
);

    logic [presc_w-1:0] div_cnt;
    logic [presc_w-1:0] div_last;
    clk_sel_e           cs_q;       // select seen last cycle
    logic               sel_chg;
    logic               running;

    always_comb begin
        running  = 1'b1;
        div_last = '0;
        case (cs)
            cs_div1:    div_last = '0;
            cs_div8:    div_last = div8_last;
            cs_div64:   div_last = div64_last;
            cs_div256:  div_last = div256_last;
            cs_div1024: div_last = div1024_last;
            default:    running  = 1'b0;   // stop and both external codes
        endcase
    end

    assign sel_chg = (cs != cs_q);

    // change cycle counts as the first cycle of the new period
    always_comb begin
        if (!running)
            tick = 1'b0;
        else if (cs == cs_div1)
            tick = 1'b1;
        else
            tick = !sel_chg && (div_cnt == div_last);
    end

    always_ff @(posedge clk_in or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            cs_q    <= cs_stop;
        end else begin
            cs_q <= cs;
            if (sel_chg)
                div_cnt <= presc_w'(1);   // restart
            else if (running)
                div_cnt <= (div_cnt >= div_last) ? '0 : div_cnt + 1'b1;
        end
    end

    a_stop_no_tick: assert property (@(posedge clk_in) disable iff (rst)
        (cs == cs_stop) |-> !tick);

endmodule

`default_nettype wire

/* hw/timer_regs.sv */
// timer register file: write decode, control and compare storage, sticky flags, read mux
`timescale 1ns/1ps
`default_nettype none

module timer_regs import timer_pkg::*; (
    input  logic              clk_in,
    input  logic              rst,
    input  bus_req_t          bus,
    input  logic [cnt_w-1:0]  count,
    input  timer_evt_t        evt,
    output logic [cnt_w-1:0]  rdata,
    output timer_ctrl_t       ctrl,
    output logic [cnt_w-1:0]  ocr_a,
    output logic [cnt_w-1:0]  ocr_b,
    output logic              cnt_load,
    output logic [cnt_w-1:0]  cnt_wdata,
    output logic              force_a,
    output logic              force_b
);

    reg_addr_e  addr;
    logic       wr_ctrl;
    logic       wr_ocr_a;
    logic       wr_ocr_b;
    logic       wr_flags;
    timer_evt_t flags;
    timer_evt_t flag_clr;
    logic [cnt_w-1:0] rd_mux;

    assign addr = reg_addr_e'(bus.addr);

    // write strobes, unused addresses fall through
    always_comb begin
        wr_ctrl  = 1'b0;
        wr_ocr_a = 1'b0;
        wr_ocr_b = 1'b0;
        wr_flags = 1'b0;
        cnt_load = 1'b0;
        if (bus.wr) begin
            case (addr)
                addr_ctrl:  wr_ctrl  = 1'b1;
                addr_cnt:   cnt_load = 1'b1;
                addr_ocr_a: wr_ocr_a = 1'b1;
                addr_ocr_b: wr_ocr_b = 1'b1;
                addr_flags: wr_flags = 1'b1;
                default: ;
            endcase
        end
    end

    assign cnt_wdata = bus.wdata;   // counter itself holds the value

    always_ff @(posedge clk_in or posedge rst) begin
        if (rst) begin
            ctrl    <= '0;
            ocr_a   <= '0;
            ocr_b   <= '0;
            force_a <= 1'b0;
            force_b <= 1'b0;
        end else begin
            if (wr_ctrl)
                ctrl <= timer_ctrl_t'(bus.wdata[7:0]);
            if (wr_ocr_a)
                ocr_a <= bus.wdata;
            if (wr_ocr_b)
                ocr_b <= bus.wdata;
            // force bits are never stored, only pulsed
            force_a <= wr_ctrl & bus.wdata[8];
            force_b <= wr_ctrl & bus.wdata[9];
        end
    end

    // write one to clear
    assign flag_clr = wr_flags ? timer_evt_t'(bus.wdata[2:0]) : '0;

    always_ff @(posedge clk_in or posedge rst) begin
        if (rst)
            flags <= '0;
        else
            flags <= (flags & ~flag_clr) | evt;   // a new event beats the clear
    end

    always_comb begin
        rd_mux = '0;
        case (addr)
            addr_ctrl:  rd_mux = {{(cnt_w-8){1'b0}}, ctrl};
            addr_cnt:   rd_mux = count;
            addr_ocr_a: rd_mux = ocr_a;
            addr_ocr_b: rd_mux = ocr_b;
            addr_flags: rd_mux = {{(cnt_w-3){1'b0}}, flags};
            default:    rd_mux = '0;
        endcase
    end

    // read data held until the next rd strobe
    always_ff @(posedge clk_in or posedge rst) begin
        if (rst)
            rdata <= '0;
        else if (bus.rd)
            rdata <= rd_mux;
    end

    // the bus issues one access per cycle
    a_no_wr_rd: assert property (@(posedge clk_in) disable iff (rst)
        !(bus.wr && bus.rd));

endmodule

`default_nettype wire

/* hw/timer_counter.sv */
// timer counter: up-count on tick, top detection, match and overflow events
`timescale 1ns/1ps
`default_nettype none

module timer_counter import timer_pkg::*; (
    input  logic             clk_in,
    input  logic             rst,
    input  logic             tick,
    input  wave_mode_e       wave,
    input  logic [cnt_w-1:0] ocr_a,
    input  logic [cnt_w-1:0] ocr_b,
    input  logic             cnt_load,
    input  logic [cnt_w-1:0] cnt_wdata,
    output logic [cnt_w-1:0] count,
    output timer_evt_t       evt
);

    logic [cnt_w-1:0] top;
    logic             at_top;
    logic             eq_a;
    logic             eq_b;

    // ctc wraps at compare A, normal runs the full range
    assign top = (wave == mode_ctc) ? ocr_a : cnt_max;

    assign at_top = (count == top);
    assign eq_a   = (count == ocr_a);
    assign eq_b   = (count == ocr_b);

    // events only exist in a tick cycle
    always_comb begin
        evt         = '0;
        evt.ovf     = tick & at_top;
        evt.match_a = tick & eq_a;
        evt.match_b = tick & eq_b;
    end

    always_ff @(posedge clk_in or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (cnt_load) begin
            count <= cnt_wdata;   // bus write wins over tick
        end else if (tick) begin
            if (at_top)
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

    a_evt_needs_tick: assert property (@(posedge clk_in) disable iff (rst)
        !tick |-> (evt == '0));

endmodule

`default_nettype wire

/* hw/timer_compare_out.sv */
// timer compare output: one output pin driven by its compare-output mode
`timescale 1ns/1ps
`default_nettype none

module timer_compare_out import timer_pkg::*; (
    input  logic      clk_in,
    input  logic      rst,
    input  logic      tick,
    input  logic      match,
    input  logic      force_cmp,
    input  com_mode_e com,
    output logic      pin
);

    logic act;       // apply the mode this cycle
    logic pin_nxt;

    assign act = force_cmp | (tick & match);

    always_comb begin
        case (com)
            com_toggle: pin_nxt = ~pin;
            com_set:    pin_nxt = 1'b1;
            com_clear:  pin_nxt = 1'b0;
            default:    pin_nxt = 1'b0;   // off parks the pin low
        endcase
    end

    always_ff @(posedge clk_in or posedge rst) begin
        if (rst)
            pin <= 1'b0;
        else if (act)
            pin <= pin_nxt;
    end

endmodule

`default_nettype wire

/* hw/timer_top.sv */
// timer top: register file, prescaler, counter and two compare output pins
`timescale 1ns/1ps
`default_nettype none

module timer_top import timer_pkg::*; (
    input  logic             clk_in,
    input  logic             rst,
    input  bus_req_t         bus,
    output logic [cnt_w-1:0] rdata,
    output logic             oc_a,
    output logic             oc_b
);

    timer_ctrl_t      ctrl;
    logic [cnt_w-1:0] ocr_a;
    logic [cnt_w-1:0] ocr_b;
    logic             cnt_load;
    logic [cnt_w-1:0] cnt_wdata;
    logic             force_a;
    logic             force_b;
    logic             tick;
    logic [cnt_w-1:0] count;
    timer_evt_t       evt;

    timer_regs u_regs (
        .clk_in    (clk_in),
        .rst       (rst),
        .bus       (bus),
        .count     (count),
        .evt       (evt),
        .rdata     (rdata),
        .ctrl      (ctrl),
        .ocr_a     (ocr_a),
        .ocr_b     (ocr_b),
        .cnt_load  (cnt_load),
        .cnt_wdata (cnt_wdata),
        .force_a   (force_a),
        .force_b   (force_b)
    );

    timer_prescaler u_presc (
        .clk_in (clk_in),
        .rst    (rst),
        .cs     (ctrl.cs),
        .tick   (tick)
    );

    timer_counter u_cnt (
        .clk_in    (clk_in),
        .rst       (rst),
        .tick      (tick),
        .wave      (ctrl.wave),
        .ocr_a     (ocr_a),
        .ocr_b     (ocr_b),
        .cnt_load  (cnt_load),
        .cnt_wdata (cnt_wdata),
        .count     (count),
        .evt       (evt)
    );

    timer_compare_out u_out_a (
        .clk_in    (clk_in),
        .rst       (rst),
        .tick      (tick),
        .match     (evt.match_a),
        .force_cmp (force_a),
        .com       (ctrl.com_a),
        .pin       (oc_a)
    );

    timer_compare_out u_out_b (
        .clk_in    (clk_in),
        .rst       (rst),
        .tick      (tick),
        .match     (evt.match_b),
        .force_cmp (force_b),
        .com       (ctrl.com_b),
        .pin       (oc_b)
    );

endmodule

`default_nettype wire

/* bench/timer_model.svh */
// timer reference model: prescaler phase, counter, flags, read data and pins stepped per clock
`ifndef TIMER_MODEL_SVH
`define TIMER_MODEL_SVH

timer_ctrl_t      m_ctrl;
logic [cnt_w-1:0] m_ocr_a, m_ocr_b, m_count, m_rdata;
timer_evt_t       m_flags;
logic             m_oc_a, m_oc_b;
logic             m_force_a, m_force_b;   // pulse pending for the next edge
int               m_phase;                // cycles since the last select change

function automatic int ratio_of(input clk_sel_e cs);
    case (cs)
        cs_div1:    return 1;
        cs_div8:    return 8;
        cs_div64:   return 64;
        cs_div256:  return 256;
        cs_div1024: return 1024;
        default:    return 0;   // stop and the external codes
    endcase
endfunction

function automatic logic com_result(input com_mode_e com, input logic pin);
    case (com)
        com_toggle: return ~pin;
        com_set:    return 1'b1;
        default:    return 1'b0;   // off and clear
    endcase
endfunction

task automatic model_reset();
    m_ctrl  = '0;
    {m_ocr_a, m_ocr_b, m_count, m_rdata} = '0;
    {m_flags, m_oc_a, m_oc_b, m_force_a, m_force_b} = '0;
    m_phase = 0;
endtask

// one clock edge with the request seen on the bus in the cycle before it
task automatic model_step(input bus_req_t b);
    int               ratio;
    logic             tick;
    logic [cnt_w-1:0] top;
    timer_evt_t       ev;
    timer_evt_t       clr;
    timer_ctrl_t      ctrl_nxt;
    ratio = ratio_of(m_ctrl.cs);
    if (ratio != 0)
        tick = ((m_phase + 1) % ratio) == 0;   // first tick ratio cycles after a change
    else
        tick = 1'b0;
    top = (m_ctrl.wave == mode_ctc) ? m_ocr_a : '1;
    ev         = '0;
    ev.ovf     = tick && (m_count == top);
    ev.match_a = tick && (m_count == m_ocr_a);
    ev.match_b = tick && (m_count == m_ocr_b);
    if (b.rd) begin
        case (b.addr)
            addr_ctrl:  m_rdata = cnt_w'(m_ctrl);
            addr_cnt:   m_rdata = m_count;
            addr_ocr_a: m_rdata = m_ocr_a;
            addr_ocr_b: m_rdata = m_ocr_b;
            addr_flags: m_rdata = cnt_w'(m_flags);
            default:    m_rdata = '0;
        endcase
    end
    if (m_force_a || ev.match_a)
        m_oc_a = com_result(m_ctrl.com_a, m_oc_a);
    if (m_force_b || ev.match_b)
        m_oc_b = com_result(m_ctrl.com_b, m_oc_b);
    clr     = (b.wr && b.addr == addr_flags) ? timer_evt_t'(b.wdata[2:0]) : '0;
    m_flags = (m_flags & ~clr) | ev;   // set beats clear
    if (b.wr && b.addr == addr_cnt)
        m_count = b.wdata;
    else if (tick)
        m_count = (m_count == top) ? '0 : m_count + 1'b1;
    m_force_a = b.wr && (b.addr == addr_ctrl) && b.wdata[8];
    m_force_b = b.wr && (b.addr == addr_ctrl) && b.wdata[9];
    ctrl_nxt  = (b.wr && b.addr == addr_ctrl) ? timer_ctrl_t'(b.wdata[7:0]) : m_ctrl;
    m_phase   = (ctrl_nxt.cs != m_ctrl.cs) ? 0 : m_phase + 1;
    m_ctrl    = ctrl_nxt;
    if (b.wr && b.addr == addr_ocr_a)
        m_ocr_a = b.wdata;
    if (b.wr && b.addr == addr_ocr_b)
        m_ocr_b = b.wdata;
endtask

`endif

/* bench/tb_timer.sv */
// timer testbench: LFSR bus stimulus checked cycle by cycle against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_timer import timer_pkg::*; ();

    localparam int max_cycles = 60000;   // all tests together stay far below

    logic             clk_in;
    logic             rst;
    bus_req_t         bus;
    logic [cnt_w-1:0] rdata;
    logic             oc_a;
    logic             oc_b;
    logic [31:0]      lfsr;
    int               cycles = 0;
    int               err_count = 0;

    `include "timer_model.svh"

    timer_top u_timer_top (
        .clk_in (clk_in),
        .rst    (rst),
        .bus    (bus),
        .rdata  (rdata),
        .oc_a   (oc_a),
        .oc_b   (oc_b)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        if (rst)
            model_reset();
        else
            model_step(bus);
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the test sequence did not finish within %0d cycles", cycles);
            $display("Errors found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // pins compared every cycle while both sides are settled
    always @(negedge clk_in) begin
        if (!rst) begin
            check_value("oc_a pin", 32'(m_oc_a), 32'(oc_a));
            check_value("oc_b pin", 32'(m_oc_b), 32'(oc_b));
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [cnt_w-1:0] ctrl_word(input wave_mode_e wave,
        input com_mode_e com_a, input com_mode_e com_b, input clk_sel_e cs,
        input logic [1:0] force_ba);
        return {6'b0, force_ba, cs, com_b, com_a, wave};
    endfunction

    task automatic bus_write(input logic [addr_w-1:0] reg_addr, input logic [cnt_w-1:0] data);
        @(posedge clk_in);
        bus <= '{wr: 1'b1, rd: 1'b0, addr: reg_addr, wdata: data};
        @(posedge clk_in);
        bus <= '0;
    endtask

    task automatic bus_read(input logic [addr_w-1:0] reg_addr, output logic [cnt_w-1:0] data);
        @(posedge clk_in);
        bus <= '{wr: 1'b0, rd: 1'b1, addr: reg_addr, wdata: '0};
        @(posedge clk_in);
        bus <= '0;
        @(negedge clk_in);
        data = rdata;
        check_value($sformatf("read of register %0d", reg_addr), 32'(m_rdata), 32'(rdata));
    endtask

    initial begin
        logic [cnt_w-1:0] val;
        logic [cnt_w-1:0] got;
        logic [cnt_w-1:0] ocr_val;
        timer_evt_t       flags_rd;
        int               toggles;
        logic             prev_pin;
        logic             exp_a;
        logic             exp_b;
        lfsr = 32'h6b2eafbb;
        rst  = 1'b1;
        bus  = '0;
        model_reset();
        repeat (8) @(posedge clk_in);
        rst <= 1'b0;

        // register readback
        repeat (4) begin
            val = cnt_w'(random_bits(16));
            bus_write(addr_ocr_a, val);
            bus_read(addr_ocr_a, got);
            check_value("ocr_a readback", 32'(val), 32'(got));
            val = cnt_w'(random_bits(16));
            bus_write(addr_ocr_b, val);
            bus_read(addr_ocr_b, got);
            check_value("ocr_b readback", 32'(val), 32'(got));
        end
        val = cnt_w'(16'h0300 | random_bits(8));   // force bits ride along
        bus_write(addr_ctrl, val);
        bus_read(addr_ctrl, got);
        check_value("ctrl readback", 32'(val[7:0]), 32'(got));
        bus_write(3'd6, 16'hffff);
        bus_read(3'd6, got);
        check_value("unused address", 0, 32'(got));

        // normal mode at /1 across the wrap
        bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_off, cs_stop, 2'b00));
        bus_write(addr_flags, 16'h0007);
        bus_write(addr_cnt, cnt_w'(16'hffc0 | random_bits(5)));
        bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_off, cs_div1, 2'b00));
        repeat (6) begin
            repeat (random_bits(3)) @(posedge clk_in);
            bus_read(addr_cnt, got);
        end
        repeat (64) @(posedge clk_in);
        bus_read(addr_flags, got);
        flags_rd = got[2:0];
        check_value("ovf flag after wrap", 1, 32'(flags_rd.ovf));
        bus_write(addr_flags, 16'h0001);
        bus_read(addr_flags, got);
        flags_rd = got[2:0];
        check_value("ovf flag cleared", 0, 32'(flags_rd.ovf));

        // clear on match, toggle on channel A
        bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_off, cs_stop, 2'b00));
        bus_write(addr_cnt, 16'h0000);
        ocr_val = cnt_w'(3 + random_bits(4));
        bus_write(addr_ocr_a, ocr_val);
        bus_write(addr_ctrl, ctrl_word(mode_ctc, com_toggle, com_off, cs_div1, 2'b00));
        repeat (20) begin
            repeat (random_bits(3)) @(posedge clk_in);
            bus_read(addr_cnt, got);
            check_value("ctc count within compare A", 1, 32'(got <= ocr_val));
        end
        prev_pin = oc_a;
        toggles  = 0;
        repeat (4 * (ocr_val + 1)) begin
            @(negedge clk_in);
            if (oc_a != prev_pin)
                toggles++;
            prev_pin = oc_a;
        end
        check_value("oc_a toggles in four periods", 4, toggles);

        // prescaler ratios
        for (int s = int'(cs_div8); s <= int'(cs_div1024); s++) begin
            bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_off, cs_stop, 2'b00));
            bus_write(addr_cnt, 16'h0000);
            bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_off, clk_sel_e'(s), 2'b00));
            repeat (2 * ratio_of(clk_sel_e'(s)) + random_bits(10)) @(posedge clk_in);
            bus_read(addr_cnt, got);
        end
        bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_off, cs_stop, 2'b00));
        bus_read(addr_cnt, got);
        val = m_count;   // model count once stopped
        repeat (40 + random_bits(6)) @(posedge clk_in);
        bus_read(addr_cnt, got);
        check_value("count frozen while stopped", 32'(val), 32'(got));

        // set then clear on channel B, starting from a forced low pin
        ocr_val = cnt_w'(8 + random_bits(6));
        bus_write(addr_ocr_b, ocr_val);
        bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_clear, cs_stop, 2'b10));
        for (int m = 0; m < 2; m++) begin
            bus_write(addr_cnt, 16'h0000);
            bus_write(addr_flags, 16'h0007);
            bus_write(addr_ctrl, ctrl_word(mode_normal, com_off,
                (m == 0) ? com_set : com_clear, cs_div1, 2'b00));
            repeat (ocr_val + 8) @(posedge clk_in);
            @(negedge clk_in);
            check_value("oc_b after match", 32'(m == 0), 32'(oc_b));
            bus_read(addr_flags, got);
            flags_rd = got[2:0];
            check_value("match_b flag", 1, 32'(flags_rd.match_b));
            bus_write(addr_ctrl, ctrl_word(mode_normal, com_off, com_off, cs_stop, 2'b00));
        end

        // force compare, counter stopped
        repeat (4) begin
            @(negedge clk_in);
            val   = cnt_w'(random_bits(4));
            exp_a = com_result(com_mode_e'(val[1:0]), m_oc_a);
            exp_b = com_result(com_mode_e'(val[3:2]), m_oc_b);
            bus_write(addr_ctrl, ctrl_word(mode_normal, com_mode_e'(val[1:0]),
                com_mode_e'(val[3:2]), cs_stop, 2'b11));
            @(posedge clk_in);
            @(negedge clk_in);
            check_value("oc_a after force", 32'(exp_a), 32'(oc_a));
            check_value("oc_b after force", 32'(exp_b), 32'(oc_b));
        end

        repeat (4) @(posedge clk_in);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
hw/timer_pkg.sv
hw/timer_prescaler.sv
hw/timer_regs.sv
hw/timer_counter.sv
hw/timer_compare_out.sv
hw/timer_top.sv
bench/tb_timer.sv

/* run_sim.sh */
#!/bin/sh
# build the timer testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_timer -f flist.f -o sim_timer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_timer > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "simulation passed"
exit 0
